// ==== verilog/a2card_pkg.sv ====
// Shared widths, card priorities and bus structs; struct field order is part of the port layout
`default_nettype none

package a2card_pkg;

    // Clock domain crossing
    localparam int SYNC_STAGES     = 2;
    localparam int DENOISE_SAMPLES = 2;

    // Card responders, lower index wins the bus
    localparam int NUM_CARDS         = 4;
    localparam int CARD_SERIAL       = 0;
    localparam int CARD_SPRITE       = 1;
    localparam int CARD_MOCKINGBOARD = 2;
    localparam int CARD_DISK         = 3;

    localparam int BUS_DATA_W = 8;
    localparam int AUDIO_W    = 16;
    localparam int MB_AUDIO_W = 10;

    // Left shifts that line the narrow sources up with the 16 bit mix
    localparam int MB_SHIFT      = 5;
    localparam int SPEAKER_SHIFT = 13;

    // Recovered Apple II bus timing in the logic clock domain
    typedef struct packed {
        logic phi1;
        logic phi0;
        logic phi1_posedge;
        logic phi1_negedge;
        logic clk_2m_posedge;
        logic clk_7m;
        logic clk_7m_posedge;
        logic clk_7m_negedge;
        logic clk_14m_posedge;
    } bus_timing_t;

    typedef struct packed {
        logic                  rd_en;
        logic [BUS_DATA_W-1:0] data;
        logic                  irq_n;
    } card_resp_t;

    typedef struct packed {
        logic                  data_oe;
        logic [BUS_DATA_W-1:0] data;
        logic                  irq_n;
    } bus_drive_t;

    // Mockingboard samples are unsigned, the rest two's complement
    typedef struct packed {
        logic signed [AUDIO_W-1:0] glu_l;
        logic signed [AUDIO_W-1:0] glu_r;
        logic signed [AUDIO_W-1:0] sprite;
        logic [MB_AUDIO_W-1:0]     mb_l;
        logic [MB_AUDIO_W-1:0]     mb_r;
        logic                      speaker;
    } audio_src_t;

    typedef struct packed {
        logic [AUDIO_W-1:0] left;
        logic [AUDIO_W-1:0] right;
    } audio_mix_t;

endpackage

`default_nettype wire

// ==== verilog/edge_denoise.sv ====
// Needs DENOISE_SAMPLES >= 2 and SYNC_STAGES >= 2; input pulses shorter than DENOISE_SAMPLES are lost
`timescale 1ns/1ns
`default_nettype none

module edge_denoise (
    input  wire  clk_logic_w,
    input  wire  rst_n_i,
    input  wire  sig_i,
    output logic level_o,
    output logic level_n_o,
    output logic posedge_o,
    output logic negedge_o
);

    logic [a2card_pkg::SYNC_STAGES-1:0]     sync_q;
    logic [a2card_pkg::DENOISE_SAMPLES-2:0] hist_q;
    logic [a2card_pkg::DENOISE_SAMPLES-1:0] window;
    logic                                   level_q;
    logic                                   level_d;

    // Newest synchronized sample plus the ones just before it
    assign window = {hist_q, sync_q[a2card_pkg::SYNC_STAGES-1]};

    // Level moves only when the whole window agrees
    always_comb begin
        level_d = level_q;
        if (&window) begin
            level_d = 1'b1;
        end else if (~|window) begin
            level_d = 1'b0;
        end
    end

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q    <= '0;
            hist_q    <= '0;
            level_q   <= 1'b0;
            posedge_o <= 1'b0;
            negedge_o <= 1'b0;
        end else begin
            sync_q    <= {sync_q[a2card_pkg::SYNC_STAGES-2:0], sig_i};
            hist_q    <= window[a2card_pkg::DENOISE_SAMPLES-2:0];
            level_q   <= level_d;
            // Strobes line up with the cycle the level changes
            posedge_o <= level_d & ~level_q;
            negedge_o <= ~level_d & level_q;
        end
    end

    assign level_o   = level_q;
    assign level_n_o = ~level_q;

endmodule

`default_nettype wire

// ==== verilog/bus_timing.sv ====
// Phi1 and 7M must be far slower than clk_logic_w; all levels lag the bus pins by about 4 cycles
`timescale 1ns/1ns
`default_nettype none

module bus_timing (
    input  wire                     clk_logic_w,
    input  wire                     rst_n_i,
    input  wire                     a2_phi1_i,
    input  wire                     a2_7m_i,
    output a2card_pkg::bus_timing_t timing_o
);

    logic phi1;
    logic phi0;
    logic phi1_posedge;
    logic phi1_negedge;
    logic clk_7m;
    logic clk_7m_posedge;
    logic clk_7m_negedge;

    // Phi0 is simply the other half of the Phi1 cycle
    edge_denoise phi1_denoise_i (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .sig_i       (a2_phi1_i),
        .level_o     (phi1),
        .level_n_o   (phi0),
        .posedge_o   (phi1_posedge),
        .negedge_o   (phi1_negedge)
    );

    edge_denoise clk_7m_denoise_i (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .sig_i       (a2_7m_i),
        .level_o     (clk_7m),
        .level_n_o   (),
        .posedge_o   (clk_7m_posedge),
        .negedge_o   (clk_7m_negedge)
    );

    // Both edges of a clock give a strobe at twice its rate
    assign timing_o.phi1            = phi1;
    assign timing_o.phi0            = phi0;
    assign timing_o.phi1_posedge    = phi1_posedge;
    assign timing_o.phi1_negedge    = phi1_negedge;
    assign timing_o.clk_2m_posedge  = phi1_posedge | phi1_negedge;
    assign timing_o.clk_7m          = clk_7m;
    assign timing_o.clk_7m_posedge  = clk_7m_posedge;
    assign timing_o.clk_7m_negedge  = clk_7m_negedge;
    assign timing_o.clk_14m_posedge = clk_7m_posedge | clk_7m_negedge;

endmodule

`default_nettype wire

// ==== verilog/reset_sync.sv ====
// Resets assert asynchronously and release SYNC_STAGES cycles later; a2_reset_n_i may be async
`timescale 1ns/1ns
`default_nettype none

module reset_sync (
    input  wire  clk_logic_w,
    input  wire  rst_n_i,
    input  wire  a2_reset_n_i,
    output logic device_rst_n_o,
    output logic system_rst_n_o
);

    logic [a2card_pkg::SYNC_STAGES-1:0] dev_q;
    logic [a2card_pkg::SYNC_STAGES-2:0] bus_q;
    logic [a2card_pkg::SYNC_STAGES-1:0] bus_chain;
    logic                               sys_q;

    // Bus reset chain, the combining flop below is its last stage
    assign bus_chain = {bus_q, a2_reset_n_i};

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dev_q <= '0;
            bus_q <= '0;
            sys_q <= 1'b0;
        end else begin
            dev_q <= {dev_q[a2card_pkg::SYNC_STAGES-2:0], 1'b1};
            bus_q <= bus_chain[a2card_pkg::SYNC_STAGES-2:0];
            // System stays in reset while the Apple II holds RESET low
            sys_q <= dev_q[a2card_pkg::SYNC_STAGES-2] & bus_q[a2card_pkg::SYNC_STAGES-2];
        end
    end

    assign device_rst_n_o = dev_q[a2card_pkg::SYNC_STAGES-1];
    assign system_rst_n_o = sys_q;

endmodule

`default_nettype wire

// ==== verilog/card_response_arbiter.sv ====
// Fixed priority for exactly four cards; bus data is driven one cycle after the card responses
`timescale 1ns/1ns
`default_nettype none

module card_response_arbiter (
    input  wire                                                      clk_logic_w,
    input  wire                                                      rst_n_i,
    input  a2card_pkg::card_resp_t [a2card_pkg::NUM_CARDS-1:0]       resp_i,
    input  wire                    [a2card_pkg::BUS_DATA_W-1:0]      bus_data_i,
    output a2card_pkg::bus_drive_t                                   drive_o
);

    logic                              oe_d;
    logic                              irq_n_d;
    logic [a2card_pkg::BUS_DATA_W-1:0] data_d;
    a2card_pkg::bus_drive_t            drive_q;

    // Any reading card takes the bus, interrupts are wire-ANDed
    always_comb begin
        oe_d    = 1'b0;
        irq_n_d = 1'b1;
        for (int i = 0; i < a2card_pkg::NUM_CARDS; i++) begin
            oe_d    = oe_d | resp_i[i].rd_en;
            irq_n_d = irq_n_d & resp_i[i].irq_n;
        end
    end

    // Serial card first, disk last
    always_comb begin
        if (resp_i[a2card_pkg::CARD_SERIAL].rd_en) begin
            data_d = resp_i[a2card_pkg::CARD_SERIAL].data;
        end else if (resp_i[a2card_pkg::CARD_SPRITE].rd_en) begin
            data_d = resp_i[a2card_pkg::CARD_SPRITE].data;
        end else if (resp_i[a2card_pkg::CARD_MOCKINGBOARD].rd_en) begin
            data_d = resp_i[a2card_pkg::CARD_MOCKINGBOARD].data;
        end else if (resp_i[a2card_pkg::CARD_DISK].rd_en) begin
            data_d = resp_i[a2card_pkg::CARD_DISK].data;
        end else begin
            // Nobody reading, echo what is on the bus
            data_d = bus_data_i;
        end
    end

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            drive_q.data_oe <= 1'b0;
            drive_q.data    <= '0;
            drive_q.irq_n   <= 1'b1;
        end else begin
            drive_q.data_oe <= oe_d;
            drive_q.data    <= data_d;
            drive_q.irq_n   <= irq_n_d;
        end
    end

    assign drive_o = drive_q;

endmodule

`default_nettype wire

// ==== verilog/audio_mixer.sv ====
// Sums wrap at 16 bits with no saturation; loud sources together can overflow the mix
`timescale 1ns/1ns
`default_nettype none

module audio_mixer (
    input  wire                     clk_logic_w,
    input  wire                     rst_n_i,
    input  a2card_pkg::audio_src_t  src_i,
    input  wire                     speaker_en_i,
    output a2card_pkg::audio_mix_t  mix_o
);

    logic signed [a2card_pkg::AUDIO_W-1:0] sprite_half;
    logic        [a2card_pkg::AUDIO_W-1:0] mb_l_ext;
    logic        [a2card_pkg::AUDIO_W-1:0] mb_r_ext;
    logic        [a2card_pkg::AUDIO_W-1:0] spk_ext;
    logic        [a2card_pkg::AUDIO_W-1:0] spk_term;
    a2card_pkg::audio_mix_t                mix_d;
    a2card_pkg::audio_mix_t                mix_q;

    // One channel: glu + sprite/2 + aligned Mockingboard + speaker
    function automatic logic [a2card_pkg::AUDIO_W-1:0] mix_channel(
        input logic [a2card_pkg::AUDIO_W-1:0] glu,
        input logic [a2card_pkg::AUDIO_W-1:0] sprite,
        input logic [a2card_pkg::AUDIO_W-1:0] mb,
        input logic [a2card_pkg::AUDIO_W-1:0] spk
    );
        logic [a2card_pkg::AUDIO_W-1:0] mb_term;
        mb_term     = mb << a2card_pkg::MB_SHIFT;
        mix_channel = glu + sprite + mb_term + spk;
    endfunction

    // Sprite is signed, halve it keeping the sign
    assign sprite_half = src_i.sprite >>> 1;

    assign mb_l_ext = {{(a2card_pkg::AUDIO_W - a2card_pkg::MB_AUDIO_W){1'b0}}, src_i.mb_l};
    assign mb_r_ext = {{(a2card_pkg::AUDIO_W - a2card_pkg::MB_AUDIO_W){1'b0}}, src_i.mb_r};

    // Speaker is a single bit, gated by its enable
    assign spk_ext  = {{(a2card_pkg::AUDIO_W - 1){1'b0}}, src_i.speaker & speaker_en_i};
    assign spk_term = spk_ext << a2card_pkg::SPEAKER_SHIFT;

    assign mix_d.left  = mix_channel(src_i.glu_l, sprite_half, mb_l_ext, spk_term);
    assign mix_d.right = mix_channel(src_i.glu_r, sprite_half, mb_r_ext, spk_term);

    always_ff @(posedge clk_logic_w or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mix_q <= '0;
        end else begin
            mix_q <= mix_d;
        end
    end

    assign mix_o = mix_q;

endmodule

`default_nettype wire

// ==== verilog/a2card_top.sv ====
// Card responses and audio arrive pre-sampled in the clk_logic_w domain; bus pins need no IO buffers
`timescale 1ns/1ns
`default_nettype none

module a2card_top (
    input  wire                                                  clk_logic_w,
    input  wire                                                  rst_n_i,
    input  wire                                                  a2_reset_n_i,
    input  wire                                                  a2_phi1_i,
    input  wire                                                  a2_7m_i,
    input  wire                    [a2card_pkg::BUS_DATA_W-1:0]  a2_data_i,
    input  a2card_pkg::card_resp_t [a2card_pkg::NUM_CARDS-1:0]   card_resp_i,
    input  a2card_pkg::audio_src_t                               audio_src_i,
    input  wire                                                  speaker_en_i,
    output a2card_pkg::bus_timing_t                              timing_o,
    output logic                                                 device_rst_n_o,
    output logic                                                 system_rst_n_o,
    output a2card_pkg::bus_drive_t                               bus_drive_o,
    output a2card_pkg::audio_mix_t                               audio_o
);

    logic device_rst_n;
    logic system_rst_n;

    // Bus clocks into the logic domain, on the raw board reset
    bus_timing bus_timing_i (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .a2_phi1_i   (a2_phi1_i),
        .a2_7m_i     (a2_7m_i),
        .timing_o    (timing_o)
    );

    reset_sync reset_sync_i (
        .clk_logic_w    (clk_logic_w),
        .rst_n_i        (rst_n_i),
        .a2_reset_n_i   (a2_reset_n_i),
        .device_rst_n_o (device_rst_n),
        .system_rst_n_o (system_rst_n)
    );

    // Card merge and mixer run on the synchronized device reset
    card_response_arbiter card_response_arbiter_i (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (device_rst_n),
        .resp_i      (card_resp_i),
        .bus_data_i  (a2_data_i),
        .drive_o     (bus_drive_o)
    );

    audio_mixer audio_mixer_i (
        .clk_logic_w  (clk_logic_w),
        .rst_n_i      (device_rst_n),
        .src_i        (audio_src_i),
        .speaker_en_i (speaker_en_i),
        .mix_o        (audio_o)
    );

    assign device_rst_n_o = device_rst_n;
    assign system_rst_n_o = system_rst_n;

endmodule

`default_nettype wire

// ==== tb/tb_a2card_top.sv ====
// Bus clocks toggle far slower than the 20 ns logic clock; random stimulus repeats from one fixed seed
`timescale 1ns/1ns
`default_nettype none

module tb_a2card_top;

    logic                                               clk_logic_w = 1'b0;
    logic                                               rst_n_i;
    logic                                               a2_reset_n_i;
    logic                                               a2_phi1_i;
    logic                                               a2_7m_i;
    logic                   [a2card_pkg::BUS_DATA_W-1:0] a2_data_i;
    a2card_pkg::card_resp_t [a2card_pkg::NUM_CARDS-1:0]  card_resp_i;
    a2card_pkg::audio_src_t                             audio_src_i;
    logic                                               speaker_en_i;
    a2card_pkg::bus_timing_t                            timing;
    logic                                               device_rst_n;
    logic                                               system_rst_n;
    a2card_pkg::bus_drive_t                             bus_drive;
    a2card_pkg::audio_mix_t                             audio;
    logic                   [5:0]                       strobe_vec;
    a2card_pkg::bus_drive_t                             exp_drive;
    a2card_pkg::audio_mix_t                             exp_audio;
    logic                                               model_valid = 1'b0;
    logic                   [31:0]                      lfsr_state = 32'h753;

    a2card_top dut_i (
        .clk_logic_w    (clk_logic_w),
        .rst_n_i        (rst_n_i),
        .a2_reset_n_i   (a2_reset_n_i),
        .a2_phi1_i      (a2_phi1_i),
        .a2_7m_i        (a2_7m_i),
        .a2_data_i      (a2_data_i),
        .card_resp_i    (card_resp_i),
        .audio_src_i    (audio_src_i),
        .speaker_en_i   (speaker_en_i),
        .timing_o       (timing),
        .device_rst_n_o (device_rst_n),
        .system_rst_n_o (system_rst_n),
        .bus_drive_o    (bus_drive),
        .audio_o        (audio)
    );

    always #10 clk_logic_w = ~clk_logic_w;

    assign strobe_vec = {timing.phi1_posedge, timing.phi1_negedge, timing.clk_2m_posedge,
                         timing.clk_7m_posedge, timing.clk_7m_negedge, timing.clk_14m_posedge};

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string msg);
        abort_run($sformatf("error at %0t ns: %s", $time, msg));
    endtask

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // Lowest index reader wins, otherwise the bus byte is echoed
    function automatic a2card_pkg::bus_drive_t expect_drive(
        input a2card_pkg::card_resp_t [a2card_pkg::NUM_CARDS-1:0] resp,
        input logic [7:0] bus
    );
        a2card_pkg::bus_drive_t d;
        logic                   found;
        d.data_oe = 1'b0;
        d.data    = bus;
        d.irq_n   = 1'b1;
        found     = 1'b0;
        for (int i = 0; i < a2card_pkg::NUM_CARDS; i++) begin
            if (resp[i].rd_en && !found) begin
                d.data = resp[i].data;
                found  = 1'b1;
            end
            d.data_oe = d.data_oe | resp[i].rd_en;
            d.irq_n   = d.irq_n & resp[i].irq_n;
        end
        return d;
    endfunction

    function automatic logic [15:0] expect_channel(
        input logic [15:0] glu,
        input logic [15:0] sprite,
        input logic [9:0]  mb,
        input logic        spk
    );
        logic [15:0] sprite_half;
        logic [15:0] mb_term;
        logic [15:0] spk_term;
        sprite_half = {sprite[15], sprite[15:1]};
        mb_term     = 16'(mb) << a2card_pkg::MB_SHIFT;
        spk_term    = spk ? (16'd1 << a2card_pkg::SPEAKER_SHIFT) : 16'd0;
        return glu + sprite_half + mb_term + spk_term;
    endfunction

    function automatic a2card_pkg::audio_mix_t expect_audio(
        input a2card_pkg::audio_src_t src,
        input logic                   spk_en
    );
        a2card_pkg::audio_mix_t m;
        m.left  = expect_channel(src.glu_l, src.sprite, src.mb_l, src.speaker & spk_en);
        m.right = expect_channel(src.glu_r, src.sprite, src.mb_r, src.speaker & spk_en);
        return m;
    endfunction

    // Level, rising strobe, falling strobe, double-rate strobe of one bus clock
    function automatic logic [3:0] clock_view(input logic use_7m);
        if (use_7m) begin
            return {timing.clk_7m, timing.clk_7m_posedge, timing.clk_7m_negedge,
                    timing.clk_14m_posedge};
        end
        return {timing.phi1, timing.phi1_posedge, timing.phi1_negedge, timing.clk_2m_posedge};
    endfunction

    task automatic set_bus_clock(input logic use_7m, input logic val);
        if (use_7m) begin
            a2_7m_i <= val;
        end else begin
            a2_phi1_i <= val;
        end
    endtask

    // Model sees the same pre-edge inputs as the DUT
    always @(posedge clk_logic_w) begin
        if (device_rst_n) begin
            exp_drive   <= expect_drive(card_resp_i, a2_data_i);
            exp_audio   <= expect_audio(audio_src_i, speaker_en_i);
            model_valid <= 1'b1;
        end else begin
            model_valid <= 1'b0;
        end
    end

    always @(negedge clk_logic_w) begin
        if (model_valid) begin
            assert (bus_drive == exp_drive)
                else flag_mismatch($sformatf("bus drive %h, expected %h", bus_drive, exp_drive));
            assert (audio == exp_audio)
                else flag_mismatch($sformatf("audio mix %h, expected %h", audio, exp_audio));
        end
    end

    phi0_inverse: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        timing.phi0 == !timing.phi1)
        else flag_mismatch("phi0 is not the inverse of phi1");

    strobe_width: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        (strobe_vec != 6'd0) |=> ((strobe_vec & $past(strobe_vec)) == 6'd0))
        else flag_mismatch("an edge strobe stayed high for more than one cycle");

    task automatic check_bus_edge(input logic use_7m, input logic val);
        logic [3:0] view;
        int         hits;
        int         hit_at;
        hits   = 0;
        hit_at = -1;
        @(posedge clk_logic_w);
        set_bus_clock(use_7m, val);
        for (int n = 0; n < 10; n++) begin
            @(negedge clk_logic_w);
            view = clock_view(use_7m);
            assert (view[0] == (view[2] | view[1]))
                else flag_mismatch("double-rate strobe does not follow the clock edges");
            assert (!(val ? view[1] : view[2]))
                else flag_mismatch("strobe fired for the opposite edge");
            if (val ? view[2] : view[1]) begin
                hits++;
                hit_at = n;
                assert (view[3] == val) else flag_mismatch("level did not move with its strobe");
            end
        end
        assert (hits == 1) else flag_mismatch($sformatf("%0d edge strobes, expected 1", hits));
        assert (hit_at >= 2 && hit_at <= 5)
            else flag_mismatch($sformatf("edge strobe %0d cycles after the input", hit_at));
        assert (view[3] == val) else flag_mismatch("level does not follow the bus clock");
    endtask

    // One-cycle pulse away from the held level
    task automatic check_glitch(input logic use_7m);
        logic [3:0] view;
        logic       steady;
        steady = use_7m ? a2_7m_i : a2_phi1_i;
        @(posedge clk_logic_w);
        set_bus_clock(use_7m, ~steady);
        @(posedge clk_logic_w);
        set_bus_clock(use_7m, steady);
        for (int n = 0; n < 8; n++) begin
            @(negedge clk_logic_w);
            view = clock_view(use_7m);
            assert (view[2:0] == 3'b000) else flag_mismatch("strobe after a one-cycle pulse");
            assert (view[3] == steady) else flag_mismatch("level moved after a one-cycle pulse");
        end
    endtask

    task automatic check_reset_values();
        assert (strobe_vec == 6'd0 && !timing.phi1)
            else flag_mismatch("bus timing not cleared by reset");
        assert (!device_rst_n && !system_rst_n) else flag_mismatch("resets not asserted");
        assert (!bus_drive.data_oe && bus_drive.irq_n && bus_drive.data == 8'h00)
            else flag_mismatch($sformatf("bus drive %h during reset", bus_drive));
        assert (audio == '0) else flag_mismatch($sformatf("audio %h during reset", audio));
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!(device_rst_n && system_rst_n) && n < 8) begin
            @(negedge clk_logic_w);
            n++;
        end
        if (!(device_rst_n && system_rst_n)) begin
            abort_run("device or system reset still low 8 cycles after board reset release");
        end
    endtask

    task automatic check_reset_combine();
        int n;
        @(posedge clk_logic_w);
        a2_reset_n_i <= 1'b0;
        n = 0;
        while (system_rst_n && n < 4) begin
            @(negedge clk_logic_w);
            assert (device_rst_n) else flag_mismatch("device reset followed the bus reset");
            n++;
        end
        if (system_rst_n) begin
            abort_run("system reset did not assert within 4 cycles of the bus reset");
        end
        repeat (5) begin
            @(negedge clk_logic_w);
            assert (device_rst_n && !system_rst_n)
                else flag_mismatch("resets wrong while the bus reset is held");
        end
        @(posedge clk_logic_w);
        a2_reset_n_i <= 1'b1;
        n = 0;
        while (!system_rst_n && n < 4) begin
            @(negedge clk_logic_w);
            n++;
        end
        if (!system_rst_n) begin
            abort_run("system reset did not release within 4 cycles of the bus reset release");
        end
    endtask

    // Roughly a quarter of the cards read in a cycle
    task automatic drive_random_cycle(input logic toggle_spk);
        a2card_pkg::card_resp_t [a2card_pkg::NUM_CARDS-1:0] resp;
        a2card_pkg::audio_src_t                             src;
        logic [7:0]                                         bus;
        for (int i = 0; i < a2card_pkg::NUM_CARDS; i++) begin
            resp[i].rd_en = (rand_bits(2) == 32'd3);
            resp[i].data  = 8'(rand_bits(8));
            resp[i].irq_n = (rand_bits(2) != 32'd0);
        end
        src.glu_l   = 16'(rand_bits(16));
        src.glu_r   = 16'(rand_bits(16));
        src.sprite  = 16'(rand_bits(16));
        src.mb_l    = 10'(rand_bits(10));
        src.mb_r    = 10'(rand_bits(10));
        src.speaker = 1'(rand_bits(1));
        bus         = 8'(rand_bits(8));
        @(posedge clk_logic_w);
        card_resp_i <= resp;
        audio_src_i <= src;
        a2_data_i   <= bus;
        if (toggle_spk) begin
            speaker_en_i <= ~speaker_en_i;
        end
    endtask

    initial begin
        int n;
        rst_n_i      = 1'b0;
        a2_reset_n_i = 1'b1;
        a2_phi1_i    = 1'b0;
        a2_7m_i      = 1'b0;
        a2_data_i    = '0;
        card_resp_i  = '0;
        for (int i = 0; i < a2card_pkg::NUM_CARDS; i++) begin
            card_resp_i[i].irq_n = 1'b1;
        end
        audio_src_i  = '0;
        speaker_en_i = 1'b0;
        @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        check_reset_values();
        @(posedge clk_logic_w);
        rst_n_i <= 1'b1;
        wait_reset_release();
        for (n = 0; n < 3; n++) begin
            check_bus_edge(1'b0, 1'b1);
            check_glitch(1'b0);
            check_bus_edge(1'b0, 1'b0);
            check_glitch(1'b0);
            check_bus_edge(1'b1, 1'b1);
            check_glitch(1'b1);
            check_bus_edge(1'b1, 1'b0);
            check_glitch(1'b1);
        end
        check_reset_combine();
        for (n = 0; n < 400; n++) begin
            drive_random_cycle(n % 3 == 0);
        end
        repeat (2) @(negedge clk_logic_w);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
verilog/a2card_pkg.sv
verilog/edge_denoise.sv
verilog/bus_timing.sv
verilog/reset_sync.sv
verilog/card_response_arbiter.sv
verilog/audio_mixer.sv
verilog/a2card_top.sv
tb/tb_a2card_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_a2card_top
FILELIST := filelist.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
